//--- rtl/cache_pkg.sv
/*
 * cache geometry constants, vector typedefs, controller state enum
 * and the cpu and burst RAM request/response structs
 */
`default_nettype none

package cache_pkg;

  // geometry: 8 words per line, 2 lines, 4 beats of 64 bits per line
  localparam int data_bits       = 32;
  localparam int words_per_line  = 8;
  localparam int line_count      = 2;
  localparam int beats_per_burst = 4;
  localparam int beat_bits       = 64;
  localparam int words_per_beat  = 2;
  localparam int ram_addr_bits   = 8;
  localparam int addr_zero_bits  = 2;
  localparam int tag_bits        = 26;

  typedef logic [31:0]                          addr_t;
  typedef logic [data_bits-1:0]                 word_t;
  typedef logic [data_bits/8-1:0]               byte_en_t;
  typedef logic [tag_bits-1:0]                  tag_t;
  typedef logic [$clog2(line_count)-1:0]        line_ix_t;
  typedef logic [$clog2(words_per_line)-1:0]    word_ix_t;
  typedef logic [beat_bits-1:0]                 beat_t;
  typedef logic [beat_bits/8-1:0]               beat_mask_t;
  typedef logic [ram_addr_bits-1:0]             ram_addr_t;
  typedef logic [$clog2(beats_per_burst)-1:0]   beat_ix_t;

  typedef enum logic [1:0] {
    idle,
    write_back,
    fill_wait,
    fill_data
  } cache_state_e;

  // be of zero means read
  typedef struct packed {
    logic     enable;
    addr_t    addr;
    word_t    wdata;
    byte_en_t be;
  } cpu_req_t;

  // cmd 1 is a write burst
  typedef struct packed {
    logic       cmd_en;
    logic       cmd;
    ram_addr_t  addr;
    beat_t      wr_data;
    beat_mask_t data_mask;
  } br_req_t;

  typedef struct packed {
    beat_t rd_data;
    logic  rd_data_valid;
  } br_rsp_t;

endpackage

`default_nettype wire

//--- rtl/cache_tag_store.sv
/*
 * per-line valid, dirty and tag storage with hit and dirty lookup
 */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store (
  input  wire                  clk,
  input  wire                  rst,
  input  wire cache_pkg::line_ix_t line_ix,
  input  wire cache_pkg::tag_t     tag,
  input  wire                  fill,
  input  wire                  set_dirty,
  output logic                 hit,
  output logic                 dirty,
  output cache_pkg::tag_t      victim_tag
);

  import cache_pkg::*;

  // one bit per line
  logic [line_count-1:0] valid_q;
  logic [line_count-1:0] dirty_q;

  // tags only mean something where valid is set
  tag_t tags [line_count];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill) begin
      // a new line starts clean
      valid_q[line_ix] <= 1'b1;
      dirty_q[line_ix] <= 1'b0;
    end else if (set_dirty) begin
      dirty_q[line_ix] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tags[line_ix] <= tag;
    end
  end

  // stored tag doubles as the write-back address of the victim
  assign victim_tag = tags[line_ix];

  assign hit   = valid_q[line_ix] && (victim_tag == tag);
  assign dirty = valid_q[line_ix] && dirty_q[line_ix];

  // a fill and a dirty mark never target the same cycle
  assert property (@(posedge clk) disable iff (rst) !(fill && set_dirty))
    else $error("tag store got fill and set_dirty together");

endmodule

`default_nettype wire

//--- rtl/cache_line_ram.sv
/*
 * line data array: byte-merged word write, beat fill,
 * word read for the cpu and beat read-out for write-back
 */
`timescale 1ns/1ps
`default_nettype none

module cache_line_ram (
  input  wire                      clk,
  input  wire cache_pkg::line_ix_t line_ix,
  input  wire cache_pkg::word_ix_t word_ix,
  input  wire cache_pkg::beat_ix_t beat_ix,
  input  wire                      word_we,
  input  wire cache_pkg::byte_en_t be,
  input  wire cache_pkg::word_t    wdata,
  input  wire                      beat_we,
  input  wire cache_pkg::beat_t    beat_in,
  output cache_pkg::word_t         word_out,
  output cache_pkg::beat_t         beat_out
);

  import cache_pkg::*;

  // words of every line, lower word of a beat sits at the even index
  word_t mem [line_count][words_per_line];

  always_ff @(posedge clk) begin
    if (word_we) begin
      // merge only the enabled bytes of the addressed word
      for (int b = 0; b < $bits(byte_en_t); b++) begin
        if (be[b]) begin
          mem[line_ix][word_ix][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end else if (beat_we) begin
      // one fill beat lands two consecutive words
      for (int i = 0; i < words_per_beat; i++) begin
        mem[line_ix][word_ix_t'(int'(beat_ix) * words_per_beat + i)] <=
          beat_in[i*data_bits +: data_bits];
      end
    end
  end

  // addressed word for a read hit
  assign word_out = mem[line_ix][word_ix];

  // addressed beat for the write-back burst
  always_comb begin
    beat_out = '0;
    for (int i = 0; i < words_per_beat; i++) begin
      beat_out[i*data_bits +: data_bits] =
        mem[line_ix][word_ix_t'(int'(beat_ix) * words_per_beat + i)];
    end
  end

  // controller never merges a word while a fill beat is written
  assert property (@(posedge clk) !(word_we && beat_we))
    else $error("line ram got word and beat write together");

endmodule

`default_nettype wire

//--- rtl/cache_ctrl.sv
/*
 * cache controller: FSM with burst beat counter, burst RAM command
 * generation, requested word forwarding and write miss merge
 */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  wire                      clk,
  input  wire                      rst,
  input  wire cache_pkg::cpu_req_t cpu_req,
  input  wire                      hit,
  input  wire                      dirty,
  input  wire cache_pkg::tag_t     victim_tag,
  output logic                     tag_fill,
  output logic                     set_dirty,
  output cache_pkg::beat_ix_t      beat_ix,
  output logic                     word_we,
  output logic                     beat_we,
  input  wire cache_pkg::word_t    word_out,
  input  wire cache_pkg::beat_t    beat_out,
  output cache_pkg::br_req_t       br_req,
  input  wire cache_pkg::br_rsp_t  br_rsp,
  output cache_pkg::word_t         data_out,
  output logic                     data_out_ready,
  output logic                     busy
);

  import cache_pkg::*;

  localparam beat_ix_t last_beat_ix = beat_ix_t'(beats_per_burst - 1);

  cache_state_e state;
  beat_ix_t     bcnt;
  logic         issue_rd;
  logic         merge_pending;

  // |tag|line|word|00| split of the request address
  tag_t     req_tag;
  line_ix_t req_line;
  word_ix_t req_word;
  beat_ix_t req_beat;
  logic [$clog2(words_per_beat)-1:0] req_half;
  logic     req_write;

  logic accept;
  logic filling;
  logic fill_beat;
  logic last_fill_beat;
  logic wr_hit;

  assign req_tag   = cpu_req.addr[$bits(addr_t)-1 -: tag_bits];
  assign req_line  = cpu_req.addr[addr_zero_bits + $bits(word_ix_t) +: $bits(line_ix_t)];
  assign req_word  = cpu_req.addr[addr_zero_bits +: $bits(word_ix_t)];
  assign req_beat  = req_word[$bits(word_ix_t)-1 -: $bits(beat_ix_t)];
  assign req_half  = req_word[$clog2(words_per_beat)-1:0];
  assign req_write = |cpu_req.be;

  // enable counts only while idle
  assign accept         = (state == idle) && cpu_req.enable;
  assign wr_hit         = accept && hit && req_write;
  assign filling        = (state == fill_wait) || (state == fill_data);
  assign fill_beat      = filling && br_rsp.rd_data_valid;
  assign last_fill_beat = fill_beat && (bcnt == last_beat_ix);

  // same counter walks the write-back and the fill beats
  assign beat_ix = bcnt;
  assign beat_we = fill_beat;

  // write miss merges in the first cycle with busy low,
  // addr, wdata and be must still hold there
  assign word_we = wr_hit || merge_pending;

  // line turns dirty at the end of a write miss fill, the merge follows
  assign set_dirty = wr_hit || (last_fill_beat && req_write);

  // clean miss takes the line at once, dirty miss after its last write beat
  assign tag_fill = (accept && !hit && !dirty) ||
                    ((state == write_back) && (bcnt == last_beat_ix));

  // beat address of the line base
  always_comb begin
    br_req.cmd_en    = ((state == write_back) && (bcnt == '0)) || issue_rd;
    br_req.cmd       = (state == write_back);
    br_req.addr      = (state == write_back) ?
                       ram_addr_t'({victim_tag, req_line, beat_ix_t'(0)}) :
                       ram_addr_t'({req_tag, req_line, beat_ix_t'(0)});
    br_req.wr_data   = beat_out;
    br_req.data_mask = '1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= idle;
      bcnt           <= '0;
      issue_rd       <= 1'b0;
      merge_pending  <= 1'b0;
      busy           <= 1'b0;
      data_out_ready <= 1'b0;
    end else begin
      data_out_ready <= 1'b0;
      issue_rd       <= 1'b0;
      merge_pending  <= 1'b0;
      case (state)
        idle: begin
          if (accept) begin
            if (hit) begin
              data_out_ready <= !req_write;
            end else begin
              busy <= 1'b1;
              if (dirty) begin
                state <= write_back;
              end else begin
                state    <= fill_wait;
                issue_rd <= 1'b1;
              end
            end
          end
        end
        write_back: begin
          // one beat per cycle, the RAM takes them without stalls
          bcnt <= bcnt + 1'b1;
          if (bcnt == last_beat_ix) begin
            state    <= fill_wait;
            issue_rd <= 1'b1;
          end
        end
        fill_wait: begin
          if (fill_beat) begin
            bcnt  <= bcnt + 1'b1;
            state <= fill_data;
          end
        end
        fill_data: begin
          if (fill_beat) begin
            bcnt <= bcnt + 1'b1;
          end
          if (last_fill_beat) begin
            state         <= idle;
            busy          <= 1'b0;
            merge_pending <= req_write;
          end
        end
        default: state <= idle;
      endcase
      // read miss forwards the word as soon as its beat shows up
      if (fill_beat && (bcnt == req_beat) && !req_write) begin
        data_out_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && hit) begin
      data_out <= word_out;
    end else if (fill_beat && (bcnt == req_beat)) begin
      data_out <= br_rsp.rd_data[int'(req_half) * data_bits +: data_bits];
    end
  end

  // a command starts a four beat burst, no other command inside it
  assert property (@(posedge clk) disable iff (rst)
    br_req.cmd_en |=> !br_req.cmd_en [*3])
    else $error("burst command inside a running burst");

  // read data never arrives while a new command goes out
  assert property (@(posedge clk) disable iff (rst)
    $rose(br_req.cmd_en) |-> !br_rsp.rd_data_valid)
    else $error("burst command during fill beats");

endmodule

`default_nettype wire

//--- rtl/data_cache.sv
/*
 * direct-mapped write-back data cache top: controller, tag store
 * and line ram between a word load/store port and a burst RAM
 */
`timescale 1ns/1ps
`default_nettype none

module data_cache (
  input  wire                      clk,
  input  wire                      rst,
  input  wire cache_pkg::cpu_req_t cpu_req,
  output cache_pkg::word_t         data_out,
  output logic                     data_out_ready,
  output logic                     busy,
  output cache_pkg::br_req_t       br_req,
  input  wire cache_pkg::br_rsp_t  br_rsp
);

  import cache_pkg::*;

  // lookup results
  logic hit;
  logic dirty;
  tag_t victim_tag;

  // strobes from the controller
  logic     tag_fill;
  logic     set_dirty;
  logic     word_we;
  logic     beat_we;
  beat_ix_t beat_ix;

  // line ram read paths
  word_t word_out;
  beat_t beat_out;

  cache_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .cpu_req        (cpu_req),
    .hit            (hit),
    .dirty          (dirty),
    .victim_tag     (victim_tag),
    .tag_fill       (tag_fill),
    .set_dirty      (set_dirty),
    .beat_ix        (beat_ix),
    .word_we        (word_we),
    .beat_we        (beat_we),
    .word_out       (word_out),
    .beat_out       (beat_out),
    .br_req         (br_req),
    .br_rsp         (br_rsp),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy)
  );

  // indices come straight from the request address
  cache_tag_store u_tags (
    .clk        (clk),
    .rst        (rst),
    .line_ix    (cpu_req.addr[addr_zero_bits + $bits(word_ix_t) +: $bits(line_ix_t)]),
    .tag        (cpu_req.addr[$bits(addr_t)-1 -: tag_bits]),
    .fill       (tag_fill),
    .set_dirty  (set_dirty),
    .hit        (hit),
    .dirty      (dirty),
    .victim_tag (victim_tag)
  );

  cache_line_ram u_lines (
    .clk      (clk),
    .line_ix  (cpu_req.addr[addr_zero_bits + $bits(word_ix_t) +: $bits(line_ix_t)]),
    .word_ix  (cpu_req.addr[addr_zero_bits +: $bits(word_ix_t)]),
    .beat_ix  (beat_ix),
    .word_we  (word_we),
    .be       (cpu_req.be),
    .wdata    (cpu_req.wdata),
    .beat_we  (beat_we),
    .beat_in  (br_rsp.rd_data),
    .word_out (word_out),
    .beat_out (beat_out)
  );

endmodule

`default_nettype wire

//--- bench/burst_ram_model.sv
/*
 * behavioral burst RAM with a preloaded address pattern, a fixed read gap
 * and four-beat read and masked write bursts
 */
`timescale 1ns/1ps
`default_nettype none

module burst_ram_model (
  input  wire                     clk,
  input  wire                     rst,
  input  wire cache_pkg::br_req_t br_req,
  output cache_pkg::br_rsp_t      br_rsp
);

  import cache_pkg::*;

  localparam int depth    = 2 ** ram_addr_bits;
  // idle cycles between a read command and its first beat
  localparam int read_gap = 3;

  beat_t     mem [depth];
  ram_addr_t rd_addr;
  ram_addr_t wr_addr;
  int        rd_wait;
  int        rd_left;
  int        wr_left;

  // word at byte address a holds a xor 32'h5a5a0000
  function automatic word_t preload_word(input int a);
    return word_t'(a) ^ 32'h5a5a_0000;
  endfunction

  // only bytes with their mask bit set take the new value
  function automatic beat_t apply_mask(input beat_t old_beat, input beat_t new_beat,
                                       input beat_mask_t mask);
    beat_t merged;
    merged = old_beat;
    for (int b = 0; b < $bits(beat_mask_t); b++) begin
      if (mask[b]) begin
        merged[8*b +: 8] = new_beat[8*b +: 8];
      end
    end
    return merged;
  endfunction

  initial begin
    for (int k = 0; k < depth; k++) begin
      // lower word of a beat is the lower byte address
      mem[k] = {preload_word(k * 8 + 4), preload_word(k * 8)};
    end
    br_rsp = '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      br_rsp.rd_data_valid <= 1'b0;
      rd_wait <= 0;
      rd_left <= 0;
      wr_left <= 0;
    end else begin
      br_rsp.rd_data_valid <= 1'b0;
      // beat 0 of a write burst rides with the command
      if (br_req.cmd_en && br_req.cmd) begin
        mem[br_req.addr] <= apply_mask(mem[br_req.addr], br_req.wr_data,
                                       br_req.data_mask);
        wr_addr <= br_req.addr + 1'b1;
        wr_left <= beats_per_burst - 1;
      end else if (wr_left != 0) begin
        mem[wr_addr] <= apply_mask(mem[wr_addr], br_req.wr_data, br_req.data_mask);
        wr_addr <= wr_addr + 1'b1;
        wr_left <= wr_left - 1;
      end
      // read beats follow the gap one per cycle
      if (br_req.cmd_en && !br_req.cmd) begin
        rd_addr <= br_req.addr;
        rd_wait <= read_gap - 1;
        rd_left <= beats_per_burst;
      end else if (rd_left != 0) begin
        if (rd_wait != 0) begin
          rd_wait <= rd_wait - 1;
        end else begin
          br_rsp.rd_data       <= mem[rd_addr];
          br_rsp.rd_data_valid <= 1'b1;
          rd_addr <= rd_addr + 1'b1;
          rd_left <= rd_left - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_data_cache.sv
/*
 * clock, reset, directed operation table, random operations,
 * shadow memory and checks for the data cache
 */
`timescale 1ns/1ps
`default_nettype none

module tb_data_cache;

  import cache_pkg::*;

  localparam int half_period  = 50;
  localparam int drive_delay  = 5;
  localparam int reset_cycles = 16;
  localparam int wait_limit   = 100;
  // shadow covers the whole 2 KB RAM
  localparam int shadow_words = 512;
  localparam int table_len    = 13;
  localparam int random_ops   = 80;

  // one directed operation and whether it must miss
  typedef struct packed {
    addr_t    addr;
    byte_en_t be;
    word_t    wdata;
    logic     miss;
  } op_t;

  logic     clk;
  logic     rst;
  cpu_req_t cpu_req;
  word_t    data_out;
  logic     data_out_ready;
  logic     busy;
  br_req_t  br_req;
  br_rsp_t  br_rsp;

  word_t  shadow [shadow_words];
  op_t    ops [table_len];
  integer seed;

  data_cache uut (
    .clk            (clk),
    .rst            (rst),
    .cpu_req        (cpu_req),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy),
    .br_req         (br_req),
    .br_rsp         (br_rsp)
  );

  burst_ram_model u_ram (
    .clk    (clk),
    .rst    (rst),
    .br_req (br_req),
    .br_rsp (br_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
    $display("TESTS FAILED");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic init_shadow;
    for (int w = 0; w < shadow_words; w++) begin
      shadow[w] = word_t'(w * 4) ^ 32'h5a5a_0000;
    end
  endtask

  // enabled bytes replace the old ones
  task automatic merge_shadow(input addr_t addr, input byte_en_t be, input word_t wdata);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        shadow[addr >> 2][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  // columns are address, byte enable, write data and must miss
  task automatic load_table;
    ops[0]  = {32'h0000_0004, 4'b0000, 32'h0000_0000, 1'b1};
    ops[1]  = {32'h0000_001c, 4'b0000, 32'h0000_0000, 1'b0};
    ops[2]  = {32'h0000_0008, 4'b0101, 32'hdead_beef, 1'b0};
    ops[3]  = {32'h0000_0008, 4'b0000, 32'h0000_0000, 1'b0};
    // same line index with another tag sends the dirty line back first
    ops[4]  = {32'h0000_0048, 4'b0000, 32'h0000_0000, 1'b1};
    ops[5]  = {32'h0000_0008, 4'b0000, 32'h0000_0000, 1'b1};
    // write miss into the empty line 1
    ops[6]  = {32'h0000_0124, 4'b1111, 32'h1234_abcd, 1'b1};
    ops[7]  = {32'h0000_0124, 4'b0000, 32'h0000_0000, 1'b0};
    ops[8]  = {32'h0000_0128, 4'b0000, 32'h0000_0000, 1'b0};
    ops[9]  = {32'h0000_0000, 4'b0000, 32'h0000_0000, 1'b0};
    // write miss over a dirty line
    ops[10] = {32'h0000_0064, 4'b1000, 32'ha500_0000, 1'b1};
    ops[11] = {32'h0000_0124, 4'b0000, 32'h0000_0000, 1'b1};
    ops[12] = {32'h0000_0064, 4'b0000, 32'h0000_0000, 1'b1};
  endtask

  // one enable cycle followed by waits for the word and for busy low
  task automatic run_op(input addr_t addr, input byte_en_t be, input word_t wdata,
                        input logic check_miss, input logic exp_miss);
    int n;
    int extra;
    @(posedge clk);
    #drive_delay;
    cpu_req.enable = 1'b1;
    cpu_req.addr   = addr;
    cpu_req.be     = be;
    cpu_req.wdata  = wdata;
    @(posedge clk);
    #drive_delay;
    // addr, be and wdata stay put until the next operation
    cpu_req.enable = 1'b0;
    @(negedge clk);
    if (check_miss) begin
      check_value("busy", busy, exp_miss);
    end
    if (|be) begin
      check_value("data_out_ready", data_out_ready, 1'b0);
      merge_shadow(addr, be, wdata);
    end else begin
      // a read hit answers in the cycle right after enable
      if (check_miss && !exp_miss) begin
        check_value("data_out_ready", data_out_ready, 1'b1);
      end
      n = 0;
      while (!data_out_ready) begin
        n++;
        if (n > wait_limit) begin
          report_timeout("data_out_ready for a read");
        end
        @(negedge clk);
      end
      check_value($sformatf("data_out at %h", addr), data_out, shadow[addr >> 2]);
    end
    // read strobe is a single pulse
    extra = 0;
    n = 0;
    while (busy) begin
      n++;
      if (n > wait_limit) begin
        report_timeout("busy to fall");
      end
      @(negedge clk);
      if (data_out_ready) begin
        extra++;
      end
    end
    check_value("extra data_out_ready pulses", extra, 0);
  endtask

  initial begin
    addr_t    r_addr;
    byte_en_t r_be;
    word_t    r_data;
    logic     r_write;
    cpu_req = '0;
    rst     = 1'b1;
    seed    = 32'h31cf;
    init_shadow();
    load_table();
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst = 1'b0;
    @(negedge clk);
    check_value("busy", busy, 1'b0);
    check_value("data_out_ready", data_out_ready, 1'b0);
    check_value("br_req.cmd_en", br_req.cmd_en, 1'b0);
    for (int i = 0; i < table_len; i++) begin
      run_op(ops[i].addr, ops[i].be, ops[i].wdata, 1'b1, ops[i].miss);
    end
    // random mix over the low 512 bytes where hits and misses are not predicted
    for (int i = 0; i < random_ops; i++) begin
      r_addr  = addr_t'($random(seed)) & 32'h0000_01fc;
      r_write = $random(seed);
      r_be    = r_write ? byte_en_t'($random(seed)) : '0;
      r_data  = $random(seed);
      run_op(r_addr, r_be, r_data, 1'b0, 1'b0);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/cache_pkg.sv
rtl/cache_tag_store.sv
rtl/cache_line_ram.sv
rtl/cache_ctrl.sv
rtl/data_cache.sv
bench/burst_ram_model.sv
bench/tb_data_cache.sv
